//--- if_fetch_pkg.sv
package if_fetch_pkg;

  ////////////////////
  // Widths
  ////////////////////

  // Address and instruction width
  localparam int unsigned XLEN = 32;

  // Interrupt id width for vectored mode
  localparam int unsigned IRQ_ID_W = 5;

  ////////////////////
  // Reset values
  ////////////////////

  // addi x0, x0, 0
  localparam logic [XLEN-1:0] INSTR_NOP = 32'h0000_0013;

  ////////////////////
  // Mux encodings
  ////////////////////

  // Redirect target selection
  typedef enum logic [2:0] {
    PC_BOOT      = 3'd0,
    PC_JUMP      = 3'd1,
    PC_BRANCH    = 3'd2,
    PC_EXCEPTION = 3'd3,
    PC_MRET      = 3'd4,
    PC_DRET      = 3'd5
  } pc_mux_e;

  // Exception target selection
  typedef enum logic [1:0] {
    EXC_PC_EXCEPTION = 2'd0,
    EXC_PC_IRQ       = 2'd1,
    EXC_PC_DBD       = 2'd2,
    EXC_PC_DBE       = 2'd3
  } exc_pc_mux_e;

endpackage

//--- if_fetch_ctrl.sv
module if_fetch_ctrl import if_fetch_pkg::*;
(
  input  logic                clk,
  input  logic                rst_n,

  // Redirect sources
  input  logic [XLEN-1:0]     boot_addr_i,
  input  logic [23:0]         mtvec_addr_i,
  input  logic [XLEN-1:0]     dm_halt_addr_i,
  input  logic [XLEN-1:0]     dm_exception_addr_i,
  input  logic [XLEN-1:0]     mepc_i,
  input  logic [XLEN-1:0]     dpc_i,
  input  logic [XLEN-1:0]     jump_target_i,
  input  logic [XLEN-1:0]     branch_target_i,

  // Controller requests
  input  logic                pc_set_i,
  input  pc_mux_e             pc_mux_i,
  input  exc_pc_mux_e         exc_pc_mux_i,
  input  logic [IRQ_ID_W-1:0] irq_id_i,
  input  logic                halt_if_i,
  input  logic                id_ready_i,

  // Prefetch buffer status
  input  logic                pf_valid_i,
  input  logic                pf_busy_i,

  output logic                redirect_o,
  output logic [XLEN-1:0]     redirect_addr_o,
  output logic                if_ready_o,
  output logic                if_valid_o,
  output logic                if_busy_o,
  output logic                csr_mtvec_init_o
);

  logic [XLEN-1:0] exc_pc;

  // Exception vector
  always_comb
  begin
    case (exc_pc_mux_i)
      // Non-vectored, all traps share the base
      EXC_PC_EXCEPTION: exc_pc = {mtvec_addr_i, 8'h00};
      // Vectored interrupts, one word per id
      EXC_PC_IRQ:       exc_pc = {mtvec_addr_i, 1'b0, irq_id_i, 2'b00};
      EXC_PC_DBD:       exc_pc = {dm_halt_addr_i[XLEN-1:2], 2'b00};
      EXC_PC_DBE:       exc_pc = {dm_exception_addr_i[XLEN-1:2], 2'b00};
      default:          exc_pc = {mtvec_addr_i, 8'h00};
    endcase
  end

  // Redirect target
  always_comb
  begin
    case (pc_mux_i)
      PC_BOOT:      redirect_addr_o = {boot_addr_i[XLEN-1:2], 2'b00};
      PC_JUMP:      redirect_addr_o = jump_target_i;
      PC_BRANCH:    redirect_addr_o = branch_target_i;
      PC_EXCEPTION: redirect_addr_o = exc_pc;
      // Return from trap and from debug mode
      PC_MRET:      redirect_addr_o = mepc_i;
      PC_DRET:      redirect_addr_o = dpc_i;
      default:      redirect_addr_o = {boot_addr_i[XLEN-1:2], 2'b00};
    endcase
  end

  // One pulse per pc_set
  assign redirect_o = pc_set_i;

  // mtvec init only on the boot redirect
  assign csr_mtvec_init_o = pc_set_i && (pc_mux_i == PC_BOOT);

  // IF ready follows ID unless halted
  assign if_ready_o = id_ready_i && !halt_if_i;
  assign if_valid_o = if_ready_o && pf_valid_i;

  // Busy flag, registered so it does not glitch on a flush
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      if_busy_o <= 1'b0;
    end
    else
    begin
      if_busy_o <= pf_busy_i;
    end
  end

endmodule

//--- if_prefetch_buffer.sv
module if_prefetch_buffer import if_fetch_pkg::*;
#(
  parameter int unsigned PF_DEPTH = 2
)
(
  input  logic            clk,
  input  logic            rst_n,

  // Redirect from control
  input  logic            redirect_i,
  input  logic [XLEN-1:0] redirect_addr_i,

  // Head consumed by IF
  input  logic            pop_i,

  // Transaction side
  output logic            trans_valid_o,
  input  logic            trans_ready_i,
  output logic [XLEN-1:0] trans_addr_o,

  // Response side
  input  logic            resp_valid_i,
  input  logic [XLEN-1:0] resp_rdata_i,
  input  logic            resp_fault_i,

  // FIFO head towards IF/ID
  output logic            pf_valid_o,
  output logic [XLEN-1:0] pf_instr_o,
  output logic            pf_fault_o,
  output logic [XLEN-1:0] pf_pc_o,
  output logic            pf_busy_o
);

  localparam int unsigned PTR_W = (PF_DEPTH > 1) ? $clog2(PF_DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(PF_DEPTH + 1);

  // Fetch state
  logic [XLEN-1:0]  fetch_addr_q;
  logic [XLEN-1:0]  head_pc_q;
  logic             active_q;
  logic             outstanding_q;
  logic             discard_q;

  // FIFO storage and pointers
  logic [XLEN-1:0]  fifo_instr [PF_DEPTH];
  logic             fifo_fault [PF_DEPTH];
  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W-1:0] wr_ptr_q;
  logic [CNT_W-1:0] count_q;

  logic             accept;
  logic             push;
  logic             pop;
  logic [XLEN-1:0]  aligned_addr;

  assign aligned_addr = {redirect_addr_i[XLEN-1:2], 2'b00};

  ////////////////////
  // Issue
  ////////////////////

  // One transaction in flight, and a free slot for its word
  assign trans_valid_o = active_q && !outstanding_q && !redirect_i &&
                         (count_q < CNT_W'(PF_DEPTH));
  assign trans_addr_o  = fetch_addr_q;
  assign accept        = trans_valid_o && trans_ready_i;

  // Stale responses are dropped, and anything arriving during a flush
  assign push = resp_valid_i && !discard_q && !redirect_i;
  assign pop  = pop_i && pf_valid_o;

  // Head of the FIFO, hidden in the flush cycle
  assign pf_valid_o = (count_q != '0) && !redirect_i;
  assign pf_instr_o = fifo_instr[rd_ptr_q];
  assign pf_fault_o = fifo_fault[rd_ptr_q];
  assign pf_pc_o    = head_pc_q;
  assign pf_busy_o  = outstanding_q;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      fetch_addr_q  <= '0;
      head_pc_q     <= '0;
      active_q      <= 1'b0;
      outstanding_q <= 1'b0;
      discard_q     <= 1'b0;
    end
    else
    begin
      // Idle until the first redirect after reset
      if (redirect_i)
      begin
        active_q <= 1'b1;
      end

      if (redirect_i)
      begin
        fetch_addr_q <= aligned_addr;
        head_pc_q    <= aligned_addr;
      end
      else
      begin
        // Each word holds one instruction, always +4
        if (accept)
        begin
          fetch_addr_q <= fetch_addr_q + 32'd4;
        end
        if (pop)
        begin
          head_pc_q <= head_pc_q + 32'd4;
        end
      end

      // In flight from acceptance to response
      if (accept)
      begin
        outstanding_q <= 1'b1;
      end
      else if (resp_valid_i)
      begin
        outstanding_q <= 1'b0;
      end

      // Mark a response that belongs to the old stream
      if (redirect_i)
      begin
        discard_q <= outstanding_q && !resp_valid_i;
      end
      else if (resp_valid_i)
      begin
        discard_q <= 1'b0;
      end
    end
  end

  ////////////////////
  // FIFO
  ////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end
    else if (redirect_i)
    begin
      // Flush
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end
    else
    begin
      if (push)
      begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(PF_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop)
      begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(PF_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push && !pop)
      begin
        count_q <= count_q + 1'b1;
      end
      else if (pop && !push)
      begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Word storage
  always_ff @(posedge clk)
  begin
    if (push)
    begin
      fifo_instr[wr_ptr_q] <= resp_rdata_i;
      fifo_fault[wr_ptr_q] <= resp_fault_i;
    end
  end

endmodule

//--- if_bus_gate.sv
module if_bus_gate import if_fetch_pkg::*;
#(
  parameter logic [XLEN-1:0] EXEC_BASE = 32'h0000_0000,
  parameter logic [XLEN-1:0] EXEC_SIZE = 32'h0000_8000
)
(
  input  logic            clk,
  input  logic            rst_n,

  // Transaction from the prefetch buffer
  input  logic            trans_valid_i,
  output logic            trans_ready_o,
  input  logic [XLEN-1:0] trans_addr_i,

  // Response to the prefetch buffer
  output logic            resp_valid_o,
  output logic [XLEN-1:0] resp_rdata_o,
  output logic            resp_fault_o,

  // Instruction bus
  output logic            instr_req_o,
  output logic [XLEN-1:0] instr_addr_o,
  input  logic            instr_gnt_i,
  input  logic            instr_rvalid_i,
  input  logic [XLEN-1:0] instr_rdata_i,
  input  logic            instr_err_i
);

  logic            in_region;
  logic            take;
  logic            fwd;
  logic            hold_q;
  logic            out_q;
  logic            fault_q;
  logic [XLEN-1:0] addr_q;

  // Executable region check
  assign in_region = (trans_addr_i >= EXEC_BASE) &&
                     ((trans_addr_i - EXEC_BASE) < EXEC_SIZE);

  // Accept only when nothing is pending on either path
  assign trans_ready_o = !hold_q && !out_q && !fault_q;
  assign take          = trans_valid_i && trans_ready_o;
  assign fwd           = take && in_region;

  // Request goes out in the cycle of acceptance, then holds until granted
  assign instr_req_o  = hold_q || fwd;
  // Blocked addresses never reach the bus
  assign instr_addr_o = fwd ? trans_addr_i : addr_q;

  // Bus reply, or the fault answer for a blocked fetch
  assign resp_valid_o = fault_q || (out_q && instr_rvalid_i);
  assign resp_fault_o = fault_q || instr_err_i;
  assign resp_rdata_o = resp_fault_o ? '0 : instr_rdata_i;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      hold_q  <= 1'b0;
      out_q   <= 1'b0;
      fault_q <= 1'b0;
      addr_q  <= '0;
    end
    else
    begin
      fault_q <= take && !in_region;

      if (fwd)
      begin
        addr_q <= trans_addr_i;
        // Granted at once or kept on the bus
        if (instr_gnt_i)
        begin
          out_q <= 1'b1;
        end
        else
        begin
          hold_q <= 1'b1;
        end
      end
      else if (hold_q && instr_gnt_i)
      begin
        hold_q <= 1'b0;
        out_q  <= 1'b1;
      end
      else if (out_q && instr_rvalid_i)
      begin
        out_q <= 1'b0;
      end
    end
  end

endmodule

//--- if_rvc_expand.sv
module if_rvc_expand import if_fetch_pkg::*;
(
  input  logic            clk,
  input  logic            rst_n,

  input  logic            load_i,
  input  logic            id_ready_i,

  // FIFO head
  input  logic [XLEN-1:0] pf_instr_i,
  input  logic            pf_fault_i,
  input  logic [XLEN-1:0] pf_pc_i,

  // IF/ID register
  output logic            instr_valid_o,
  output logic [XLEN-1:0] instr_o,
  output logic [XLEN-1:0] pc_o,
  output logic [15:0]     compressed_instr_o,
  output logic            is_compressed_o,
  output logic            illegal_c_o,
  output logic            fetch_fault_o
);

  logic [15:0]     c;
  logic [XLEN-1:0] instr_x;
  logic            is_c;
  logic            illegal_x;

  assign c = pf_instr_i[15:0];

  ////////////////////
  // Expansion
  ////////////////////

  always_comb
  begin
    instr_x   = pf_instr_i;
    is_c      = 1'b0;
    illegal_x = 1'b0;
    // Faulted fetches carry no instruction
    if (pf_fault_i)
    begin
      instr_x = '0;
    end
    else if (c[1:0] != 2'b11)
    begin
      is_c      = 1'b1;
      // Anything not matched below
      illegal_x = 1'b1;
      instr_x   = {16'h0000, c};
      if (c[1:0] == 2'b01)
      begin
        case (c[15:13])
          // C.ADDI, addi rd, rd, imm
          3'b000:
          begin
            instr_x   = {{6{c[12]}}, c[12], c[6:2], c[11:7], 3'b000, c[11:7], 7'b0010011};
            illegal_x = 1'b0;
          end
          // C.LI, addi rd, x0, imm
          3'b010:
          begin
            instr_x   = {{6{c[12]}}, c[12], c[6:2], 5'd0, 3'b000, c[11:7], 7'b0010011};
            illegal_x = 1'b0;
          end
          // C.J, jal x0 with the scrambled offset
          3'b101:
          begin
            instr_x   = {c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3],
                         c[12], {8{c[12]}}, 5'd0, 7'b1101111};
            illegal_x = 1'b0;
          end
          default:
          begin
          end
        endcase
      end
      else if (c[1:0] == 2'b10 && c[15:13] == 3'b100 && c[6:2] != 5'd0)
      begin
        illegal_x = 1'b0;
        if (c[12])
        begin
          // C.ADD, add rd, rd, rs2
          instr_x = {7'd0, c[6:2], c[11:7], 3'b000, c[11:7], 7'b0110011};
        end
        else
        begin
          // C.MV, add rd, x0, rs2
          instr_x = {7'd0, c[6:2], 5'd0, 3'b000, c[11:7], 7'b0110011};
        end
      end
    end
  end

  ////////////////////
  // IF/ID register
  ////////////////////

  // Frozen while ID stalls
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      instr_valid_o      <= 1'b0;
      instr_o            <= INSTR_NOP;
      pc_o               <= '0;
      compressed_instr_o <= '0;
      is_compressed_o    <= 1'b0;
      illegal_c_o        <= 1'b0;
      fetch_fault_o      <= 1'b0;
    end
    else if (load_i)
    begin
      instr_valid_o      <= 1'b1;
      instr_o            <= instr_x;
      pc_o               <= pf_pc_i;
      compressed_instr_o <= c;
      is_compressed_o    <= is_c;
      illegal_c_o        <= illegal_x;
      fetch_fault_o      <= pf_fault_i;
    end
    else if (id_ready_i)
    begin
      // ID took it, nothing new behind
      instr_valid_o <= 1'b0;
    end
  end

endmodule

//--- if_fetch_top.sv
module if_fetch_top import if_fetch_pkg::*;
#(
  parameter int unsigned     PF_DEPTH  = 2,
  parameter logic [XLEN-1:0] EXEC_BASE = 32'h0000_0000,
  parameter logic [XLEN-1:0] EXEC_SIZE = 32'h0000_8000
)
(
  input  logic                clk,
  input  logic                rst_n,
  input  logic [XLEN-1:0]     boot_addr_i,
  input  logic [23:0]         mtvec_addr_i,
  input  logic [XLEN-1:0]     dm_halt_addr_i,
  input  logic [XLEN-1:0]     dm_exception_addr_i,
  input  logic [XLEN-1:0]     mepc_i,
  input  logic [XLEN-1:0]     dpc_i,
  input  logic [XLEN-1:0]     jump_target_i,
  input  logic [XLEN-1:0]     branch_target_i,
  input  logic                pc_set_i,
  input  pc_mux_e             pc_mux_i,
  input  exc_pc_mux_e         exc_pc_mux_i,
  input  logic [IRQ_ID_W-1:0] irq_id_i,
  input  logic                halt_if_i,
  input  logic                id_ready_i,
  // Instruction bus
  output logic                instr_req_o,
  output logic [XLEN-1:0]     instr_addr_o,
  input  logic                instr_gnt_i,
  input  logic                instr_rvalid_i,
  input  logic [XLEN-1:0]     instr_rdata_i,
  input  logic                instr_err_i,
  // IF/ID outputs
  output logic                instr_valid_o,
  output logic [XLEN-1:0]     instr_o,
  output logic [XLEN-1:0]     pc_o,
  output logic [15:0]         compressed_instr_o,
  output logic                is_compressed_o,
  output logic                illegal_c_o,
  output logic                fetch_fault_o,
  output logic                if_ready_o,
  output logic                if_busy_o,
  output logic                csr_mtvec_init_o
);

  // Redirect path
  logic            redirect;
  logic [XLEN-1:0] redirect_addr;
  // Transaction and response path
  logic            trans_valid;
  logic            trans_ready;
  logic [XLEN-1:0] trans_addr;
  logic            resp_valid;
  logic [XLEN-1:0] resp_rdata;
  logic            resp_fault;
  // FIFO head
  logic            pf_valid;
  logic [XLEN-1:0] pf_instr;
  logic            pf_fault;
  logic [XLEN-1:0] pf_pc;
  logic            pf_busy;
  logic            if_valid;

  if_fetch_ctrl u_ctrl (
    .clk                 (clk),
    .rst_n               (rst_n),
    .boot_addr_i         (boot_addr_i),
    .mtvec_addr_i        (mtvec_addr_i),
    .dm_halt_addr_i      (dm_halt_addr_i),
    .dm_exception_addr_i (dm_exception_addr_i),
    .mepc_i              (mepc_i),
    .dpc_i               (dpc_i),
    .jump_target_i       (jump_target_i),
    .branch_target_i     (branch_target_i),
    .pc_set_i            (pc_set_i),
    .pc_mux_i            (pc_mux_i),
    .exc_pc_mux_i        (exc_pc_mux_i),
    .irq_id_i            (irq_id_i),
    .halt_if_i           (halt_if_i),
    .id_ready_i          (id_ready_i),
    .pf_valid_i          (pf_valid),
    .pf_busy_i           (pf_busy),
    .redirect_o          (redirect),
    .redirect_addr_o     (redirect_addr),
    .if_ready_o          (if_ready_o),
    .if_valid_o          (if_valid),
    .if_busy_o           (if_busy_o),
    .csr_mtvec_init_o    (csr_mtvec_init_o)
  );

  // IF ready pops the head
  if_prefetch_buffer #(
    .PF_DEPTH (PF_DEPTH)
  ) u_prefetch (
    .clk             (clk),
    .rst_n           (rst_n),
    .redirect_i      (redirect),
    .redirect_addr_i (redirect_addr),
    .pop_i           (if_ready_o),
    .trans_valid_o   (trans_valid),
    .trans_ready_i   (trans_ready),
    .trans_addr_o    (trans_addr),
    .resp_valid_i    (resp_valid),
    .resp_rdata_i    (resp_rdata),
    .resp_fault_i    (resp_fault),
    .pf_valid_o      (pf_valid),
    .pf_instr_o      (pf_instr),
    .pf_fault_o      (pf_fault),
    .pf_pc_o         (pf_pc),
    .pf_busy_o       (pf_busy)
  );

  if_bus_gate #(
    .EXEC_BASE (EXEC_BASE),
    .EXEC_SIZE (EXEC_SIZE)
  ) u_bus_gate (
    .clk            (clk),
    .rst_n          (rst_n),
    .trans_valid_i  (trans_valid),
    .trans_ready_o  (trans_ready),
    .trans_addr_i   (trans_addr),
    .resp_valid_o   (resp_valid),
    .resp_rdata_o   (resp_rdata),
    .resp_fault_o   (resp_fault),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i),
    .instr_err_i    (instr_err_i)
  );

  // if_valid loads the IF/ID register
  if_rvc_expand u_rvc_expand (
    .clk                (clk),
    .rst_n              (rst_n),
    .load_i             (if_valid),
    .id_ready_i         (id_ready_i),
    .pf_instr_i         (pf_instr),
    .pf_fault_i         (pf_fault),
    .pf_pc_i            (pf_pc),
    .instr_valid_o      (instr_valid_o),
    .instr_o            (instr_o),
    .pc_o               (pc_o),
    .compressed_instr_o (compressed_instr_o),
    .is_compressed_o    (is_compressed_o),
    .illegal_c_o        (illegal_c_o),
    .fetch_fault_o      (fetch_fault_o)
  );

endmodule

//--- if_fetch_props.sv
module if_fetch_props import if_fetch_pkg::*;
(
  input logic            clk,
  input logic            rst_n,
  input logic            instr_req_o,
  input logic [XLEN-1:0] instr_addr_o,
  input logic            instr_gnt_i,
  input logic            instr_rvalid_i,
  input logic            instr_valid_o,
  input logic            id_ready_i,
  input logic [XLEN-1:0] instr_o,
  input logic [XLEN-1:0] pc_o
);

  // Granted requests still waiting for rvalid
  logic [1:0] granted_q;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      granted_q <= '0;
    end
    else
    begin
      granted_q <= granted_q + 2'(instr_req_o && instr_gnt_i) - 2'(instr_rvalid_i);
    end
  end

  addr_stable_a: assert property (@(posedge clk) disable iff (!rst_n)
    instr_req_o && !instr_gnt_i |=> instr_req_o && $stable(instr_addr_o))
    else $error("instr_addr_o changed while the request waited for a grant");

  rvalid_granted_a: assert property (@(posedge clk) disable iff (!rst_n)
    instr_rvalid_i |-> granted_q != 2'd0)
    else $error("instr_rvalid_i without an outstanding grant");

  // ID stalled, IF/ID register frozen
  output_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
    instr_valid_o && !id_ready_i |=> instr_valid_o && $stable(instr_o) && $stable(pc_o))
    else $error("IF/ID outputs changed while ID was stalled");

endmodule

bind if_fetch_top if_fetch_props u_props (.*);

//--- tb_if_fetch.sv
module tb_if_fetch import if_fetch_pkg::*;
();

  localparam logic [31:0] EXEC_SIZE = 32'h0000_1000;
  localparam int          RUN_LIMIT = 600;

  logic        clk;
  logic        rst_n;
  logic [31:0] boot_addr_i;
  logic [23:0] mtvec_addr_i;
  logic [31:0] dm_halt_addr_i;
  logic [31:0] dm_exception_addr_i;
  logic [31:0] mepc_i;
  logic [31:0] dpc_i;
  logic [31:0] jump_target_i;
  logic [31:0] branch_target_i;
  logic        pc_set_i;
  pc_mux_e     pc_mux_i;
  exc_pc_mux_e exc_pc_mux_i;
  logic [4:0]  irq_id_i;
  logic        halt_if_i;
  logic        id_ready_i;
  logic        instr_req_o;
  logic [31:0] instr_addr_o;
  logic        instr_gnt_i;
  logic        instr_rvalid_i;
  logic [31:0] instr_rdata_i;
  logic        instr_err_i;
  logic        instr_valid_o;
  logic [31:0] instr_o;
  logic [31:0] pc_o;
  logic [15:0] compressed_instr_o;
  logic        is_compressed_o;
  logic        illegal_c_o;
  logic        fetch_fault_o;
  logic        if_ready_o;
  logic        if_busy_o;
  logic        csr_mtvec_init_o;

  // Memory image and error marks from the vectors
  logic [31:0] mem_data [logic [31:0]];
  bit          mem_err  [logic [31:0]];

  // Current test
  int          rd_cycle[$];
  logic [31:0] rd_mux[$];
  logic [31:0] rd_exc[$];
  logic [31:0] rd_irq[$];
  logic [31:0] rd_val[$];
  int          exp_seg[$];
  logic [31:0] exp_pc[$];
  logic [31:0] exp_instr[$];
  logic [31:0] exp_c[$];
  logic [31:0] exp_ill[$];
  logic [31:0] exp_flt[$];
  int          exp_idx;
  int          cur_seg;
  int          skip;
  bit          collecting;
  bit          exp_mtvec;
  bit          timed_out;

  int          seed;
  int          err_count;
  int          tests_run;
  int          tests_failed;

  // Bus model state
  bit          pend;
  logic [31:0] pend_addr;
  int          pend_delay;

  if_fetch_top #(
    .PF_DEPTH  (2),
    .EXEC_BASE (32'h0000_0000),
    .EXEC_SIZE (EXEC_SIZE)
  ) dut (.*);

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic compare_value(input string name, input logic [31:0] exp_v,
                               input logic [31:0] got_v);
    if (exp_v !== got_v)
    begin
      $display("Mismatch at %0t: %s expected %h got %h", $time, name, exp_v, got_v);
      err_count++;
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    tests_run++;
    if (err_count != errs_before)
    begin
      tests_failed++;
      $display("test %s: FAIL (%0d errors)", name, err_count - errs_before);
    end
    else
    begin
      $display("test %s: PASS", name);
    end
  endtask

  ////////////////////
  // Bus model
  ////////////////////

  // Sample the handshake where everything is settled
  always @(negedge clk)
  begin
    if (rst_n && instr_req_o)
    begin
      if (instr_addr_o >= EXEC_SIZE)
      begin
        $display("Error at %0t: blocked address %h reached the bus", $time, instr_addr_o);
        err_count++;
      end
      if (instr_gnt_i && !pend)
      begin
        pend       = 1'b1;
        pend_addr  = instr_addr_o;
        pend_delay = $random(seed) & 3;
      end
    end
  end

  always
  begin
    @(posedge clk);
    #1;
    instr_rvalid_i = 1'b0;
    instr_err_i    = 1'b0;
    instr_rdata_i  = '0;
    if (pend)
    begin
      if (pend_delay == 0)
      begin
        instr_rvalid_i = 1'b1;
        // Unwritten words follow an address-dependent fill
        instr_rdata_i  = mem_data.exists(pend_addr) ? mem_data[pend_addr]
                                                    : ((pend_addr ^ 32'h5a5a_a5a4) | 32'h3);
        instr_err_i    = mem_err.exists(pend_addr);
        pend           = 1'b0;
      end
      else
      begin
        pend_delay--;
      end
    end
    instr_gnt_i = !pend && (($random(seed) & 3) != 0);
  end

  ////////////////////
  // Output monitor
  ////////////////////

  always @(negedge clk)
  begin
    if (rst_n)
    begin
      // Pulse only in the cycle of a boot redirect
      compare_value("csr_mtvec_init_o", 32'(exp_mtvec), 32'(csr_mtvec_init_o));
      // IF ready is ID ready unless halted
      compare_value("if_ready_o", 32'(id_ready_i && !halt_if_i), 32'(if_ready_o));
    end
    if (skip > 0)
    begin
      skip--;
    end
    else if (collecting && instr_valid_o && id_ready_i)
    begin
      // Outputs past a segment's list are not checked
      if (exp_idx < exp_seg.size() && exp_seg[exp_idx] == cur_seg)
      begin
        compare_value("pc_o", exp_pc[exp_idx], pc_o);
        compare_value("instr_o", exp_instr[exp_idx], instr_o);
        compare_value("is_compressed_o", exp_c[exp_idx], 32'(is_compressed_o));
        compare_value("illegal_c_o", exp_ill[exp_idx], 32'(illegal_c_o));
        compare_value("fetch_fault_o", exp_flt[exp_idx], 32'(fetch_fault_o));
        if (exp_c[exp_idx] != 0)
        begin
          // Low half of the fetched word, as stored in the image
          compare_value("compressed_instr_o", mem_data[exp_pc[exp_idx]] & 32'h0000_ffff,
                        32'(compressed_instr_o));
        end
        exp_idx++;
      end
    end
  end

  // Route the source value to the input the selection reads
  task automatic drive_redirect(input int i);
    pc_set_i     = 1'b1;
    pc_mux_i     = pc_mux_e'(rd_mux[i][2:0]);
    exc_pc_mux_i = exc_pc_mux_e'(rd_exc[i][1:0]);
    irq_id_i     = rd_irq[i][4:0];
    exp_mtvec    = (rd_mux[i][2:0] == 3'd0);
    case (rd_mux[i][2:0])
      3'd0: boot_addr_i = rd_val[i];
      3'd1: jump_target_i = rd_val[i];
      3'd2: branch_target_i = rd_val[i];
      3'd4: mepc_i = rd_val[i];
      3'd5: dpc_i = rd_val[i];
      default:
      begin
        if (rd_exc[i][1:0] == 2'd2)
        begin
          dm_halt_addr_i = rd_val[i];
        end
        else if (rd_exc[i][1:0] == 2'd3)
        begin
          dm_exception_addr_i = rd_val[i];
        end
        else
        begin
          mtvec_addr_i = rd_val[i][23:0];
        end
      end
    endcase
  endtask

  task automatic run_test(input int id, input int mode);
    int cyc;
    int next;
    int hold_ready;
    int errs_before;
    errs_before = err_count;
    exp_idx     = 0;
    cyc         = 0;
    next        = 0;
    hold_ready  = 0;
    while ((next < rd_cycle.size() || exp_idx < exp_seg.size()) && cyc < RUN_LIMIT)
    begin
      @(posedge clk);
      #1;
      pc_set_i  = 1'b0;
      exp_mtvec = 1'b0;
      if (next < rd_cycle.size() && cyc == rd_cycle[next])
      begin
        // Outputs owed by the segment that ends here
        if (exp_idx < exp_seg.size() && exp_seg[exp_idx] < next)
        begin
          $display("Error at %0t: segment %0d ended before all its outputs", $time, cur_seg);
          err_count++;
          while (exp_idx < exp_seg.size() && exp_seg[exp_idx] < next)
          begin
            exp_idx++;
          end
        end
        drive_redirect(next);
        cur_seg    = next;
        collecting = 1'b1;
        skip       = 1;
        hold_ready = 2;
        next++;
      end
      if (hold_ready > 0 || mode == 0)
      begin
        id_ready_i = 1'b1;
        halt_if_i  = 1'b0;
        if (hold_ready > 0)
        begin
          hold_ready--;
        end
      end
      else
      begin
        id_ready_i = (($random(seed) & 3) != 0);
        halt_if_i  = (($random(seed) & 7) == 0);
      end
      cyc++;
    end
    collecting = 1'b0;
    if (cyc >= RUN_LIMIT)
    begin
      $display("Timeout: test %0d delivered %0d of %0d outputs", id, exp_idx, exp_seg.size());
      err_count++;
      timed_out = 1'b1;
    end
    @(posedge clk);
    #1;
    id_ready_i = 1'b1;
    halt_if_i  = 1'b0;
    report_test($sformatf("%0d", id), errs_before);
  endtask

  initial
  begin
    int          fd;
    int          id;
    int          mode;
    int          cyc_v;
    int          seg_v;
    int          errs_before;
    string       tok;
    string       line;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    logic [31:0] d;
    logic [31:0] e;
    seed = 42;
    err_count = 0;
    tests_run = 0;
    tests_failed = 0;
    rst_n = 1'b0;
    boot_addr_i = '0;
    mtvec_addr_i = '0;
    dm_halt_addr_i = '0;
    dm_exception_addr_i = '0;
    mepc_i = '0;
    dpc_i = '0;
    jump_target_i = '0;
    branch_target_i = '0;
    pc_set_i = 1'b0;
    pc_mux_i = PC_BOOT;
    exc_pc_mux_i = EXC_PC_EXCEPTION;
    irq_id_i = '0;
    halt_if_i = 1'b0;
    id_ready_i = 1'b1;
    instr_gnt_i = 1'b0;
    instr_rvalid_i = 1'b0;
    instr_rdata_i = '0;
    instr_err_i = 1'b0;
    pend = 1'b0;
    collecting = 1'b0;
    exp_mtvec = 1'b0;
    timed_out = 1'b0;
    skip = 0;
    cur_seg = 0;
    id = 0;
    mode = 0;
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // Idle state after reset
    errs_before = err_count;
    @(negedge clk);
    compare_value("instr_req_o", 32'd0, 32'(instr_req_o));
    compare_value("instr_valid_o", 32'd0, 32'(instr_valid_o));
    compare_value("csr_mtvec_init_o", 32'd0, 32'(csr_mtvec_init_o));
    compare_value("if_busy_o", 32'd0, 32'(if_busy_o));
    report_test("reset", errs_before);

    fd = $fopen("if_fetch_vectors.txt", "r");
    if (fd == 0)
    begin
      $display("Error: cannot open if_fetch_vectors.txt");
      err_count++;
    end
    else
    begin
      while (!timed_out && $fscanf(fd, "%s", tok) == 1)
      begin
        if (tok == "#")
        begin
          void'($fgets(line, fd));
        end
        else if (tok == "m")
        begin
          void'($fscanf(fd, "%h %h %h", a, b, c));
          mem_data[a] = b;
          if (c[0])
          begin
            mem_err[a] = 1'b1;
          end
        end
        else if (tok == "t")
        begin
          void'($fscanf(fd, "%d %d", id, mode));
          rd_cycle.delete();
          rd_mux.delete();
          rd_exc.delete();
          rd_irq.delete();
          rd_val.delete();
          exp_seg.delete();
          exp_pc.delete();
          exp_instr.delete();
          exp_c.delete();
          exp_ill.delete();
          exp_flt.delete();
        end
        else if (tok == "r")
        begin
          void'($fscanf(fd, "%d %h %h %h %h", cyc_v, a, b, c, d));
          rd_cycle.push_back(cyc_v);
          rd_mux.push_back(a);
          rd_exc.push_back(b);
          rd_irq.push_back(c);
          rd_val.push_back(d);
        end
        else if (tok == "e")
        begin
          void'($fscanf(fd, "%d %h %h %h %h %h", seg_v, a, b, c, d, e));
          exp_seg.push_back(seg_v);
          exp_pc.push_back(a);
          exp_instr.push_back(b);
          exp_c.push_back(c);
          exp_ill.push_back(d);
          exp_flt.push_back(e);
        end
        else if (tok == "x")
        begin
          run_test(id, mode);
        end
        else
        begin
          $display("Error: unknown vector record %s", tok);
          err_count++;
        end
      end
      $fclose(fd);
    end

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_count);
    if (err_count == 0)
    begin
      $display("TESTBENCH PASSED");
    end
    else
    begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

//--- if_fetch_vectors.txt
# m addr data err | t id mode(1=back-pressure) | r cycle pc_mux exc_mux irq value | x runs test
# e segment pc instr is_compressed illegal_c fault
m 80 00500093 0
m 84 00108113 0
m 88 002081b3 0
m 8c 00000013 0
m 90 00a00093 0
m 94 00b00093 0
m 100 00100093 0
m 140 00200093 0
m 200 00300093 0
m 214 00400093 0
m 300 00500093 0
m 340 00600093 0
m 400 00700093 0
m 440 00800093 0
m 180 dead008d 0
m 184 0000517d 0
m 188 00008192 0
m 18c 0000929a 0
m 190 0000a021 0
m 194 00004188 0
m ff8 00900093 0
m ffc 12345678 1
# boot and sequential fetch
t 1 0
r 0 0 0 0 00000082
e 0 80 00500093 0 0 0
e 0 84 00108113 0 0 0
e 0 88 002081b3 0 0 0
e 0 8c 00000013 0 0 0
x
# one redirect per target selection
t 2 0
r 0 1 0 0 00000100
r 14 2 0 0 00000140
r 28 3 0 0 00000002
r 42 3 1 5 00000002
r 56 3 2 0 00000303
r 70 3 3 0 00000342
r 84 4 0 0 00000400
r 98 5 0 0 00000440
e 0 100 00100093 0 0 0
e 1 140 00200093 0 0 0
e 2 200 00300093 0 0 0
e 3 214 00400093 0 0 0
e 4 300 00500093 0 0 0
e 5 340 00600093 0 0 0
e 6 400 00700093 0 0 0
e 7 440 00800093 0 0 0
x
# compressed expansion
t 3 0
r 0 1 0 0 00000180
e 0 180 00308093 1 0 0
e 0 184 fff00113 1 0 0
e 0 188 004001b3 1 0 0
e 0 18c 006282b3 1 0 0
e 0 190 0080006f 1 0 0
e 0 194 00004188 1 1 0
x
# bus error then region fault
t 4 0
r 0 2 0 0 00000ff8
e 0 ff8 00900093 0 0 0
e 0 ffc 00000000 0 0 1
e 0 1000 00000000 0 0 1
e 0 1004 00000000 0 0 1
x
# back-pressure and halt
t 5 1
r 0 1 0 0 00000080
e 0 80 00500093 0 0 0
e 0 84 00108113 0 0 0
e 0 88 002081b3 0 0 0
e 0 8c 00000013 0 0 0
e 0 90 00a00093 0 0 0
e 0 94 00b00093 0 0 0
x

//--- if_fetch.f
if_fetch_pkg.sv
if_fetch_ctrl.sv
if_prefetch_buffer.sv
if_bus_gate.sv
if_rvc_expand.sv
if_fetch_top.sv
if_fetch_props.sv
tb_if_fetch.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_if_fetch
DUT_TOP   ?= if_fetch_top
FILELIST  ?= if_fetch.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "TESTBENCH PASSED" $(LOG); then echo "simulation incomplete"; exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
